// ==== logic/eth_frame_pkg.sv ====
package eth_frame_pkg;

  // Basic widths
  localparam int BYTE_W = 8;
  localparam int WORD_W = 32;                      // Buffer word, four bytes
  localparam int LEN_W  = 11;                      // Frame length in bytes, up to 2047
  localparam int ADDR_W = 9;                       // Buffer word address

  // Preamble and start of frame delimiter
  localparam int PREAMBLE_BYTES = 7;
  localparam logic [BYTE_W-1:0] PREAMBLE_BYTE = 8'h55;
  localparam logic [BYTE_W-1:0] SFD_BYTE      = 8'hD5;

  // Frame check sequence, IEEE 802.3 CRC-32 in reflected form
  localparam int FCS_W = 32;
  localparam logic [FCS_W-1:0] CRC_POLY = 32'hEDB8_8320;
  localparam logic [FCS_W-1:0] CRC_INIT = '1;

  // Idle tail after the FCS, two bit times of high line
  localparam int TAIL_CYCLES = 4;

  // Normal link pulse
  localparam int LINK_PULSE_CYCLES = 2;            // High cycles per pulse
  localparam int LINK_PULSE_CNT_W  = $clog2(LINK_PULSE_CYCLES + 1);

endpackage

// ==== logic/tx_path_pkg.sv ====
package tx_path_pkg;

  import eth_frame_pkg::*;

  // Serializer bit counter covers the whole preamble with SFD
  localparam int PREAMBLE_BITS = (PREAMBLE_BYTES + 1) * BYTE_W;
  localparam int SFD_FIRST_BIT = PREAMBLE_BYTES * BYTE_W;
  localparam int BIT_CNT_W     = $clog2(PREAMBLE_BITS);

  // Byte lane index inside a buffer word
  localparam int LANE_W = $clog2(WORD_W / BYTE_W);

  // Payload byte from frame_fetch
  typedef struct packed {
    logic [BYTE_W-1:0] data;
    logic              last;                       // Final byte of the frame
  } tx_byte_t;

  // Half-bit symbol from tx_serializer to manchester_line
  typedef struct packed {
    logic active;                                  // Frame bit on the line
    logic bit_val;
    logic half;                                    // 0 first half, 1 second half
    logic tail;                                    // Idle tail level
  } line_sym_t;

  // Completion status, pulses for one cycle
  typedef struct packed {
    logic done;
    logic aborted;
  } tx_status_t;

  // Serializer FSM
  typedef enum logic [2:0] {
    IDLE,
    PREAMBLE,
    PAYLOAD,
    FCS,
    TAIL
  } tx_state_e;

endpackage

// ==== logic/frame_fetch.sv ====
`timescale 1ns/100ps

module frame_fetch
  import eth_frame_pkg::*;
  import tx_path_pkg::*;
(
  input  logic              CLK,
  input  logic              RST,
  input  logic              start,
  input  logic [LEN_W-1:0]  frame_len,
  input  logic              byte_take,
  output logic              rd_en,
  output logic [ADDR_W-1:0] rd_addr,
  input  logic [WORD_W-1:0] rd_data,
  output tx_byte_t          cur_byte
);

  localparam logic [LANE_W-1:0] LAST_LANE = LANE_W'(WORD_W / BYTE_W - 1);

  logic [WORD_W-1:0] word_q;
  logic [LANE_W-1:0] lane;
  logic [LEN_W-1:0]  remain;                       // Bytes not yet taken
  logic              rd_pend;                      // Buffer answers this cycle

  always_ff @(posedge CLK)
  begin
    if (!RST)
    begin
      rd_en   <= 1'b0;
      rd_addr <= '0;
      rd_pend <= 1'b0;
      lane    <= '0;
      remain  <= '0;
    end
    else
    begin
      rd_en   <= 1'b0;
      rd_pend <= rd_en;

      if (start)
      begin
        rd_en   <= 1'b1;                           // First word of the frame
        rd_addr <= '0;
        lane    <= '0;
        remain  <= frame_len;
      end
      else if (byte_take)
      begin
        lane   <= lane + 1'b1;
        remain <= remain - 1'b1;
        // Word used up, fetch the next one if bytes are left
        if (lane == LAST_LANE && remain > LEN_W'(1))
        begin
          rd_en   <= 1'b1;
          rd_addr <= rd_addr + 1'b1;
        end
      end
    end
  end

  // Word register
  always_ff @(posedge CLK)
  begin
    if (rd_pend)
      word_q <= rd_data;
  end

  // Lane 0 is the top byte of the word
  always_comb
  begin
    cur_byte.data = word_q[(WORD_W - BYTE_W) - BYTE_W * int'(lane) +: BYTE_W];
    cur_byte.last = (remain == LEN_W'(1));
  end

endmodule

// ==== logic/crc32_serial.sv ====
`timescale 1ns/100ps

module crc32_serial
  import eth_frame_pkg::*;
  import tx_path_pkg::*;
(
  input  logic             CLK,
  input  logic             RST,
  input  logic             start,
  input  logic             byte_take,
  input  tx_byte_t         cur_byte,
  output logic [FCS_W-1:0] fcs
);

  logic [FCS_W-1:0]  crc_q;
  logic [BYTE_W-1:0] data_sh;
  logic [2:0]        step;
  logic              running;
  logic              fb;

  assign fb  = crc_q[0] ^ data_sh[0];              // Feedback bit, LSB first
  assign fcs = ~crc_q;

  always_ff @(posedge CLK)
  begin
    if (!RST)
    begin
      running <= 1'b0;
      step    <= '0;
    end
    else if (start)
    begin
      running <= 1'b0;
      step    <= '0;
    end
    else if (byte_take)
    begin
      running <= 1'b1;
      step    <= '0;
    end
    else if (running)
    begin
      step <= step + 1'b1;
      if (step == 3'd7)
        running <= 1'b0;                           // Eight bits absorbed
    end
  end

  always_ff @(posedge CLK)
  begin
    if (start)
      crc_q <= CRC_INIT;
    else if (byte_take)
      data_sh <= cur_byte.data;
    else if (running)
    begin
      crc_q   <= (crc_q >> 1) ^ (fb ? CRC_POLY : '0);
      data_sh <= data_sh >> 1;
    end
  end

endmodule

// ==== logic/tx_serializer.sv ====
`timescale 1ns/100ps

module tx_serializer
  import eth_frame_pkg::*;
  import tx_path_pkg::*;
(
  input  logic             CLK,
  input  logic             RST,
  input  logic             start,
  input  logic             abort,
  input  tx_byte_t         cur_byte,
  input  logic [FCS_W-1:0] fcs,
  output logic             byte_take,
  output line_sym_t        sym,
  output logic             busy,
  output tx_status_t       status
);

  tx_state_e              state;
  logic                   half;
  logic [BIT_CNT_W-1:0]   bit_cnt;
  logic [FCS_W-1:0]       shreg;                   // Bit 0 goes out next
  logic                   last_q;                  // Byte in shreg is the last one
  logic                   abort_q;
  logic                   byte_end;
  logic                   take_now;

  assign byte_end = half && (bit_cnt[2:0] == 3'(BYTE_W - 1));

  // Next payload byte is needed after the SFD and after every non-last byte
  assign take_now = half &&
                    ((state == PREAMBLE && bit_cnt == BIT_CNT_W'(PREAMBLE_BITS - 1)) ||
                     (state == PAYLOAD && byte_end && !last_q));

  always_ff @(posedge CLK)
  begin
    if (!RST)
    begin
      state     <= IDLE;
      half      <= 1'b0;
      bit_cnt   <= '0;
      last_q    <= 1'b0;
      abort_q   <= 1'b0;
      byte_take <= 1'b0;
      sym       <= '0;
      busy      <= 1'b0;
      status    <= '0;
    end
    else
    begin
      byte_take <= 1'b0;
      status    <= '0;

      if (abort && state != IDLE)
      begin
        state   <= IDLE;                           // Drop the frame without a tail
        sym     <= '0;
        abort_q <= 1'b1;
      end
      else
      begin
        case (state)
          IDLE:
          begin
            sym <= '0;
            if (abort_q)
            begin
              abort_q <= 1'b0;
              busy    <= 1'b0;
              status  <= '{done: 1'b1, aborted: 1'b1};
            end
            else if (start && !busy)
            begin
              state   <= PREAMBLE;
              half    <= 1'b0;
              bit_cnt <= '0;
              shreg   <= FCS_W'(PREAMBLE_BYTE);
              busy    <= 1'b1;
            end
          end

          TAIL:
          begin
            // High for TAIL_CYCLES then one low cycle before done
            sym <= '{active: 1'b0, bit_val: 1'b0, half: 1'b0,
                     tail: (bit_cnt < BIT_CNT_W'(TAIL_CYCLES))};
            if (bit_cnt == BIT_CNT_W'(TAIL_CYCLES + 1))
            begin
              state  <= IDLE;
              busy   <= 1'b0;
              status <= '{done: 1'b1, aborted: 1'b0};
            end
            else
              bit_cnt <= bit_cnt + 1'b1;
          end

          default:
          begin
            sym  <= '{active: 1'b1, bit_val: shreg[0], half: half, tail: 1'b0};
            half <= ~half;
            if (half)
            begin
              bit_cnt <= bit_cnt + 1'b1;
              shreg   <= shreg >> 1;
              if (take_now)
              begin
                state     <= PAYLOAD;
                shreg     <= FCS_W'(cur_byte.data);
                last_q    <= cur_byte.last;
                bit_cnt   <= '0;
                byte_take <= 1'b1;
              end
              else if (state == PREAMBLE && byte_end)
              begin
                // Reload the preamble byte until the SFD
                if (bit_cnt == BIT_CNT_W'(SFD_FIRST_BIT - 1))
                  shreg <= FCS_W'(SFD_BYTE);
                else
                  shreg <= FCS_W'(PREAMBLE_BYTE);
              end
              else if (state == PAYLOAD && byte_end)
              begin
                state   <= FCS;                    // Last byte sent
                shreg   <= fcs;
                bit_cnt <= '0;
              end
              else if (state == FCS && bit_cnt == BIT_CNT_W'(FCS_W - 1))
              begin
                state   <= TAIL;
                bit_cnt <= '0;
              end
            end
          end
        endcase
      end
    end
  end

endmodule

// ==== logic/manchester_line.sv ====
`timescale 1ns/100ps

module manchester_line
  import eth_frame_pkg::*;
  import tx_path_pkg::*;
(
  input  logic      CLK,
  input  logic      RST,
  input  line_sym_t sym,
  input  logic      link_pulse,
  output logic      line
);

  logic [LINK_PULSE_CNT_W-1:0] pulse_cnt;         // High cycles still owed

  always_ff @(posedge CLK)
  begin
    if (!RST)
    begin
      line      <= 1'b0;
      pulse_cnt <= '0;
    end
    else if (sym.active)
    begin
      // Complement first, true bit second
      line      <= sym.half ? sym.bit_val : ~sym.bit_val;
      pulse_cnt <= '0;
    end
    else if (sym.tail)
    begin
      line      <= 1'b1;
      pulse_cnt <= '0;
    end
    else if (link_pulse)
    begin
      line      <= 1'b1;
      pulse_cnt <= LINK_PULSE_CNT_W'(LINK_PULSE_CYCLES - 1);
    end
    else if (pulse_cnt != '0)
    begin
      line      <= 1'b1;                           // Stretch the pulse
      pulse_cnt <= pulse_cnt - 1'b1;
    end
    else
      line <= 1'b0;
  end

endmodule

// ==== logic/eth_tx_top.sv ====
`timescale 1ns/100ps

module eth_tx_top
  import eth_frame_pkg::*;
  import tx_path_pkg::*;
(
  input  logic              CLK,
  input  logic              RST,
  input  logic              start,
  input  logic [LEN_W-1:0]  frame_len,
  input  logic              abort,
  input  logic              link_pulse,
  output logic              rd_en,
  output logic [ADDR_W-1:0] rd_addr,
  input  logic [WORD_W-1:0] rd_data,
  output logic              line,
  output logic              busy,
  output tx_status_t        status
);

  tx_byte_t         cur_byte;
  logic             byte_take;
  logic [FCS_W-1:0] fcs;
  line_sym_t        sym;

  frame_fetch u_fetch (
    .CLK       (CLK),
    .RST       (RST),
    .start     (start),
    .frame_len (frame_len),
    .byte_take (byte_take),
    .rd_en     (rd_en),
    .rd_addr   (rd_addr),
    .rd_data   (rd_data),
    .cur_byte  (cur_byte)
  );

  crc32_serial u_crc (
    .CLK       (CLK),
    .RST       (RST),
    .start     (start),
    .byte_take (byte_take),
    .cur_byte  (cur_byte),
    .fcs       (fcs)
  );

  tx_serializer u_ser (
    .CLK       (CLK),
    .RST       (RST),
    .start     (start),
    .abort     (abort),
    .cur_byte  (cur_byte),
    .fcs       (fcs),
    .byte_take (byte_take),
    .sym       (sym),
    .busy      (busy),
    .status    (status)
  );

  manchester_line u_line (
    .CLK        (CLK),
    .RST        (RST),
    .sym        (sym),
    .link_pulse (link_pulse),
    .line       (line)
  );

endmodule

// ==== dv/eth_tx_properties.sv ====
`timescale 1ns/100ps

module eth_tx_properties
  import tx_path_pkg::*;
(
  input logic       CLK,
  input logic       RST,
  input logic       link_pulse,
  input logic       rd_en,
  input logic       line,
  input logic       busy,
  input tx_status_t status
);

  done_busy_a: assert property (@(posedge CLK) disable iff (!RST)
    status.done |-> $fell(busy))
    else $error("status.done without busy falling");

  aborted_done_a: assert property (@(posedge CLK) disable iff (!RST)
    status.aborted |-> status.done)
    else $error("status.aborted without status.done");

  reset_idle_a: assert property (@(posedge CLK) $rose(RST) |-> (!busy && !rd_en))
    else $error("busy or rd_en high right after reset");

  // Idle line is high only in the two cycles after a link pulse strobe
  idle_line_a: assert property (@(posedge CLK) disable iff (!RST)
    (!busy && line) |-> ($past(link_pulse) || $past(link_pulse, 2)))
    else $error("line high while idle outside a link pulse");

endmodule

bind eth_tx_top eth_tx_properties u_props (
  .CLK        (CLK),
  .RST        (RST),
  .link_pulse (link_pulse),
  .rd_en      (rd_en),
  .line       (line),
  .busy       (busy),
  .status     (status)
);

// ==== dv/eth_tx_tb.sv ====
`timescale 1ns/100ps

module eth_tx_tb
  import eth_frame_pkg::*;
  import tx_path_pkg::*;
();

  localparam int HALF_PERIOD    = 50;
  localparam int DRIVE_DELAY    = 10;              // Inputs change after the rising edge
  localparam int TIMEOUT_CYCLES = 40000;           // Longer than a 2047 byte frame
  localparam int NUM_TESTS      = 8;

  typedef struct packed {
    logic [LEN_W-1:0] len;
    logic [15:0]      abort_at;                    // Cycle after start, 0 for none
    logic             link;
    logic             exp_aborted;
  } test_entry_t;

  logic              CLK;
  logic              RST;
  logic              start;
  logic              abort;
  logic              link_pulse;
  logic              rd_en;
  logic              line;
  logic              busy;
  logic [LEN_W-1:0]  frame_len;
  logic [ADDR_W-1:0] rd_addr;
  logic [ADDR_W-1:0] rd_addr_q;
  logic [WORD_W-1:0] rd_data;
  tx_status_t        status;
  logic [WORD_W-1:0] buf_mem [2**ADDR_W];
  test_entry_t       tests [NUM_TESTS];
  string             test_names [NUM_TESTS];
  logic              line_q [$];                   // Line level, one entry per cycle
  logic              busy_q [$];
  int                seed;

  eth_tx_top u_dut (.*);

  initial CLK = 1'b0;
  always #HALF_PERIOD CLK = ~CLK;

  // Buffer model, answers one cycle after rd_en
  initial
  begin
    rd_data = '0;
    forever
    begin
      @(posedge CLK);
      if (rd_en)
      begin
        rd_addr_q = rd_addr;
        #DRIVE_DELAY;
        rd_data = buf_mem[rd_addr_q];
      end
    end
  end

  task automatic fail_now(input string msg);
    begin
      $display("%s", msg);
      $display("Simulation finished: FAIL");
      $fatal(1, "Stopping at the first error");
    end
  endtask

  task automatic check_value(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
    begin
      if (actual !== expected)
        fail_now($sformatf("Error: test %s expected 0x%0h actual 0x%0h",
                           name, expected, actual));
    end
  endtask

  // Byte k of the frame, word bits 31:24 come first
  function automatic logic [7:0] payload_byte(input int k);
    logic [WORD_W-1:0] w;
    begin
      w = buf_mem[ADDR_W'(k / 4)] >> (8 * (3 - k % 4));
      payload_byte = w[7:0];
    end
  endfunction

  // Reflected CRC-32 over the payload, sent complemented
  function automatic logic [FCS_W-1:0] ref_fcs(input int len);
    logic [FCS_W-1:0] crc;
    int               k;
    int               b;
    begin
      crc = CRC_INIT;
      for (k = 0; k < len; k++)
      begin
        crc = crc ^ FCS_W'(payload_byte(k));
        for (b = 0; b < 8; b++)
          crc = crc[0] ? ((crc >> 1) ^ CRC_POLY) : (crc >> 1);
      end
      ref_fcs = ~crc;
    end
  endfunction

  // Rebuilds n bits, LSB first, from the second half of each bit
  function automatic logic [31:0] decode_bits(input int first, input int n);
    logic [31:0] v;
    int          i;
    begin
      v = '0;
      for (i = n - 1; i >= 0; i--)
        v = {v[30:0], line_q[3 + 2 * (first + i)]};
      decode_bits = v;
    end
  endfunction

  task automatic run_frame(input test_entry_t t, input string name);
    logic [7:0] exp_bytes [$];
    tx_status_t done_st;
    int         c;
    int         i;
    int         done_c;
    int         n_bits;
    int         n_bytes;
    int         exp_done;
    begin
      for (i = 0; i < PREAMBLE_BYTES; i++)
        exp_bytes.push_back(PREAMBLE_BYTE);
      exp_bytes.push_back(SFD_BYTE);
      for (i = 0; i < int'(t.len); i++)
        exp_bytes.push_back(payload_byte(i));
      line_q.delete();
      busy_q.delete();
      start     = 1'b1;
      frame_len = t.len;
      @(posedge CLK);                              // Start sampled, cycle 0
      c      = 0;
      done_c = -1;
      while (done_c < 0)
      begin
        #DRIVE_DELAY;
        start = 1'b0;
        abort = (t.abort_at != '0) && (c + 1 == int'(t.abort_at));
        @(negedge CLK);
        line_q.push_back(line);
        busy_q.push_back(busy);
        if (status.done)
        begin
          done_c  = c;
          done_st = status;
        end
        else if (c >= TIMEOUT_CYCLES)
          fail_now($sformatf("Timeout: test %s got no done from the transmitter", name));
        @(posedge CLK);
        c++;
      end
      #DRIVE_DELAY;
      @(negedge CLK);
      check_value({name, " done pulse"}, 32'd0, 32'(status.done));   // One cycle only
      check_value({name, " line after done"}, 32'd0, 32'(line));
      if (t.exp_aborted)
      begin
        n_bits   = (int'(t.abort_at) - 1) / 2;     // Whole bits before the abort
        exp_done = int'(t.abort_at) + 1;
      end
      else
      begin
        n_bits   = 8 * (PREAMBLE_BYTES + 1 + int'(t.len)) + FCS_W;
        exp_done = 2 * n_bits + 2 + TAIL_CYCLES;
      end
      check_value({name, " done cycle"}, 32'(exp_done), 32'(done_c));
      check_value({name, " aborted flag"}, 32'(t.exp_aborted), 32'(done_st.aborted));
      for (i = 0; i <= done_c; i++)
        check_value($sformatf("%s busy cycle %0d", name, i), 32'(i < done_c), 32'(busy_q[i]));
      check_value({name, " line before frame"}, 32'd0, 32'(line_q[0] | line_q[1]));
      for (i = 0; i < n_bits; i++)
        check_value($sformatf("%s half-bit pair %0d", name, i),
                    32'(!line_q[3 + 2 * i]), 32'(line_q[2 + 2 * i]));
      n_bytes = (n_bits / 8 < exp_bytes.size()) ? n_bits / 8 : exp_bytes.size();
      for (i = 0; i < n_bytes; i++)
        check_value($sformatf("%s byte %0d", name, i), 32'(exp_bytes[i]), decode_bits(8 * i, 8));
      if (!t.exp_aborted)
      begin
        check_value({name, " FCS"}, ref_fcs(int'(t.len)), decode_bits(8 * exp_bytes.size(), FCS_W));
        for (i = 0; i < TAIL_CYCLES; i++)
          check_value($sformatf("%s tail cycle %0d", name, i), 32'd1,
                      32'(line_q[2 * n_bits + 2 + i]));
      end
      check_value({name, " line at done"}, 32'd0, 32'(line_q[done_c]));
      @(posedge CLK);
      #DRIVE_DELAY;
    end
  endtask

  task automatic run_link(input string name);
    int c;
    begin
      link_pulse = 1'b1;
      @(posedge CLK);
      for (c = 0; c < LINK_PULSE_CYCLES + 2; c++)
      begin
        #DRIVE_DELAY;
        link_pulse = 1'b0;
        @(negedge CLK);
        check_value($sformatf("%s line cycle %0d", name, c),
                    32'(c < LINK_PULSE_CYCLES), 32'(line));
        check_value($sformatf("%s busy cycle %0d", name, c), 32'd0, 32'(busy));
        @(posedge CLK);
      end
      #DRIVE_DELAY;
    end
  endtask

  initial
  begin
    int i;
    int idx;
    seed       = 32'hfa65_1e92;
    RST        = 1'b0;
    start      = 1'b0;
    frame_len  = '0;
    abort      = 1'b0;
    link_pulse = 1'b0;
    for (i = 0; i < 2**ADDR_W; i++)
      buf_mem[ADDR_W'(i)] = $random(seed);
    // Length, abort cycle, link pulse, aborted expected
    tests = '{
      '{LEN_W'(1),    16'd0,   1'b0, 1'b0},
      '{LEN_W'(5),    16'd0,   1'b0, 1'b0},
      '{LEN_W'(64),   16'd0,   1'b0, 1'b0},
      '{LEN_W'(23),   16'd0,   1'b0, 1'b0},
      '{LEN_W'(64),   16'd300, 1'b0, 1'b1},    // Mid payload
      '{LEN_W'(7),    16'd0,   1'b0, 1'b0},
      '{LEN_W'(0),    16'd0,   1'b1, 1'b0},
      '{LEN_W'(2047), 16'd0,   1'b0, 1'b0}
    };
    test_names = '{"single_byte", "five_bytes", "sixty_four", "odd_length",
                   "abort_mid", "after_abort", "link_idle", "max_length"};
    repeat (3) @(posedge CLK);
    #DRIVE_DELAY;
    RST = 1'b1;
    repeat (2) @(posedge CLK);
    #DRIVE_DELAY;
    for (idx = 0; idx < NUM_TESTS; idx++)
    begin
      if (tests[idx].link)
        run_link(test_names[idx]);
      else
        run_frame(tests[idx], test_names[idx]);
      repeat (3) @(posedge CLK);
      #DRIVE_DELAY;
    end
    $display("Simulation finished: PASS");
    $finish;
  end

endmodule

// ==== flist.f ====
logic/eth_frame_pkg.sv
logic/tx_path_pkg.sv
logic/frame_fetch.sv
logic/crc32_serial.sv
logic/tx_serializer.sv
logic/manchester_line.sv
logic/eth_tx_top.sv
dv/eth_tx_properties.sv
dv/eth_tx_tb.sv

// ==== Makefile ====
TOP := eth_tx_tb

.PHONY: lint sim clean

lint:
	verilator --lint-only -Wall --timing --assert --top-module $(TOP) -f flist.f

sim:
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) -f flist.f -o $(TOP)
	@out="$$(./obj_dir/$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "Simulation finished: PASS"

clean:
	rm -rf obj_dir
